//--- project.f
riscv_pkg.sv
forwarding_unit.sv
alu.sv
branch_unit.sv
ex_stage.sv
ex_mem_reg.sv
ex_top.sv
tb_ex_top.sv

//--- Bender.yml
package:
  name: riscv_ex_stage

sources:
  - riscv_pkg.sv
  - forwarding_unit.sv
  - alu.sv
  - branch_unit.sv
  - ex_stage.sv
  - ex_mem_reg.sv
  - ex_top.sv
  - target: simulation
    files:
      - tb_ex_top.sv

//--- tb_ex_top.sv
`default_nettype none

module tb_ex_top
    import riscv_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    id_ex_reg_t  id_ex_in;
    word_t       wb_write_data;
    reg_addr_t   wb_rd_addr;
    logic        wb_reg_write;
    logic        stall;
    logic        flush;
    logic        branch_taken;
    word_t       branch_target;
    ex_mem_reg_t ex_mem_out;

    ex_mem_reg_t exp_q;     // model copy of the registered record
    ex_mem_reg_t exp_next;
    logic        exp_taken;
    word_t       exp_target;
    int          src_a;     // 0 reg, 1 mem, 2 wb
    int          src_b;
    word_t       rs1_ref;
    word_t       rs2_ref;
    word_t       a_ref;
    word_t       b_ref;
    logic        jump_ref;
    logic [31:0] lfsr = 32'd95;
    int          errors = 0;
    int          tests = 0;
    int          mem_hits = 0;
    int          wb_hits = 0;

    ex_top UUT (
        .clk(clk), .rst_n(rst_n), .id_ex_in(id_ex_in),
        .wb_write_data(wb_write_data), .wb_rd_addr(wb_rd_addr), .wb_reg_write(wb_reg_write),
        .stall(stall), .flush(flush), .branch_taken(branch_taken),
        .branch_target(branch_target), .ex_mem_out(ex_mem_out)
    );

    always #4 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'hD000_0001;
            end
            v = {v[XLEN-2:0], b};
        end
        return v;
    endfunction

    // signed less-than from the sign bits
    function automatic logic lt_signed(input word_t a, input word_t b);
        return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
    endfunction

    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        logic [2*XLEN-1:0] ext;
        ext = {{XLEN{a[XLEN-1]}}, a};
        case (op)
            ADD:    return a + b;
            SUB:    return a + ~b + 1;
            SLL:    return a << b[4:0];
            SLT:    return {31'd0, lt_signed(a, b)};
            SLTU:   return {31'd0, a < b};
            XOR:    return a ^ b;
            SRL:    return a >> b[4:0];
            SRA:    return word_t'(ext >> b[4:0]);
            OR:     return a | b;
            AND:    return a & b;
            PASS_B: return b;
            default: return '0;
        endcase
    endfunction

    function automatic logic cond_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt_signed(a, b);
            3'b101:  return !lt_signed(a, b);
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic int src_for(input reg_addr_t idx, input ex_mem_reg_t mem,
                                   input logic wb_we, input reg_addr_t wb_rd);
        if (mem.valid_ex_mem && mem.ctrl.reg_write && mem.rd_addr != 0 && mem.rd_addr == idx) begin
            return 1;
        end
        if (wb_we && wb_rd != 0 && wb_rd == idx) begin
            return 2;
        end
        return 0;
    endfunction

    always_comb begin
        src_a    = src_for(id_ex_in.rs1_addr, exp_q, wb_reg_write, wb_rd_addr);
        src_b    = src_for(id_ex_in.rs2_addr, exp_q, wb_reg_write, wb_rd_addr);
        rs1_ref  = (src_a == 1) ? exp_q.alu_result : (src_a == 2) ? wb_write_data
                                                                  : id_ex_in.rs1_data;
        rs2_ref  = (src_b == 1) ? exp_q.alu_result : (src_b == 2) ? wb_write_data
                                                                  : id_ex_in.rs2_data;
        a_ref    = (id_ex_in.ctrl.opcode == OP_AUIPC) ? id_ex_in.pc : rs1_ref;
        b_ref    = id_ex_in.ctrl.alu_src ? id_ex_in.immediate : rs2_ref;
        jump_ref = (id_ex_in.ctrl.opcode == OP_JAL) || (id_ex_in.ctrl.opcode == OP_JALR);
        exp_next.alu_result   = jump_ref ? id_ex_in.pc + 32'd4
                                         : alu_ref(id_ex_in.ctrl.alu_op, a_ref, b_ref);
        exp_next.rs2_data_str = rs2_ref;
        exp_next.rd_addr      = id_ex_in.rd_addr;
        exp_next.ctrl         = id_ex_in.ctrl;
        exp_next.valid_ex_mem = id_ex_in.valid_id_ex;
        exp_taken  = id_ex_in.valid_id_ex && ((id_ex_in.ctrl.opcode == OP_BRANCH)
                     ? cond_ref(id_ex_in.funct3_for_branch, rs1_ref, rs2_ref) : jump_ref);
        exp_target = (id_ex_in.ctrl.opcode == OP_JALR) ? ((rs1_ref + id_ex_in.immediate) & ~32'd1)
                                                       : id_ex_in.pc + id_ex_in.immediate;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= '0;
        end else if (flush) begin
            exp_q <= '0; // bubble
        end else if (!stall) begin
            exp_q <= exp_next;
        end
    end

    always @(posedge clk) begin
        if (rst_n && id_ex_in.valid_id_ex) begin
            if (src_a == 1 || src_b == 1) mem_hits++;
            if (src_a == 2 || src_b == 2) wb_hits++;
        end
    end

    a_reset: assert property (@(posedge clk) !rst_n |-> (!ex_mem_out.valid_ex_mem
            && !ex_mem_out.ctrl.reg_write && !ex_mem_out.ctrl.mem_read
            && !ex_mem_out.ctrl.mem_write && !branch_taken))
        else begin
            errors++;
            $display("[FAIL] %0t record not idle during reset", $time);
        end
    a_record: assert property (@(posedge clk) disable iff (!rst_n) ex_mem_out == exp_q)
        else begin
            errors++;
            $display("[FAIL] %0t ex_mem_out %h, expected %h", $time,
                     $sampled(ex_mem_out), $sampled(exp_q));
        end
    a_taken: assert property (@(posedge clk) disable iff (!rst_n) branch_taken == exp_taken)
        else begin
            errors++;
            $display("[FAIL] %0t branch_taken is wrong", $time);
        end
    a_target: assert property (@(posedge clk) disable iff (!rst_n)
            exp_taken |-> branch_target == exp_target)
        else begin
            errors++;
            $display("[FAIL] %0t branch_target %h, expected %h", $time,
                     $sampled(branch_target), $sampled(exp_target));
        end
    a_invalid: assert property (@(posedge clk) disable iff (!rst_n)
            !id_ex_in.valid_id_ex |-> !branch_taken)
        else begin
            errors++;
            $display("[FAIL] %0t invalid record raised branch_taken", $time);
        end
    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
            (stall && !flush) |=> ex_mem_out == $past(ex_mem_out))
        else begin
            errors++;
            $display("[FAIL] %0t stall did not hold ex_mem_out", $time);
        end
    a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |=>
            (!ex_mem_out.valid_ex_mem && !ex_mem_out.ctrl.reg_write && !ex_mem_out.ctrl.mem_write
             && ex_mem_out.alu_result == '0 && ex_mem_out.rs2_data_str == '0))
        else begin
            errors++;
            $display("[FAIL] %0t flush did not give a bubble", $time);
        end

    function automatic id_ex_reg_t make_rec(input opcode_e op, input alu_op_e aop,
                                            input logic imm_src, input logic [2:0] f3,
                                            input reg_addr_t rs1, input reg_addr_t rs2,
                                            input reg_addr_t rd);
        id_ex_reg_t r;
        r = '0;
        r.pc        = rand_bits(30) << 2;
        r.rs1_data  = rand_bits(32);
        r.rs2_data  = rand_bits(32);
        r.immediate = rand_bits(32);
        r.rs1_addr  = rs1;
        r.rs2_addr  = rs2;
        r.rd_addr   = rd;
        r.funct3_for_branch = f3;
        r.ctrl.opcode    = op;
        r.ctrl.alu_op    = aop;
        r.ctrl.alu_src   = imm_src;
        r.ctrl.reg_write = !(op inside {OP_BRANCH, OP_STORE});
        r.ctrl.mem_read  = (op == OP_LOAD);
        r.ctrl.mem_write = (op == OP_STORE);
        r.ctrl.is_branch = (op == OP_BRANCH);
        r.ctrl.is_jump   = (op inside {OP_JAL, OP_JALR});
        r.ctrl.is_jalr   = (op == OP_JALR);
        r.valid_id_ex    = 1'b1;
        return r;
    endfunction

    task automatic drive(input id_ex_reg_t rec, input logic st, input logic fl,
                         input logic wb_we, input reg_addr_t wb_rd);
        @(posedge clk);
        #1;
        id_ex_in      = rec;
        stall         = st;
        flush         = fl;
        wb_reg_write  = wb_we;
        wb_rd_addr    = wb_rd;
        wb_write_data = rand_bits(32);
    endtask

    task automatic end_test(input string name, input int err_before);
        repeat (2) @(posedge clk); // let the registered check run
        tests++;
        $display("%-12s %s, %0d errors", name, (errors == err_before) ? "passed" : "failed",
                 errors - err_before);
    endtask

    task automatic wait_out_valid(input int max_cycles);
        int n;
        n = 0;
        while (!ex_mem_out.valid_ex_mem && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ex_mem_out.valid_ex_mem) begin
            errors++;
            $display("timeout while waiting for a valid EX/MEM record");
        end
    endtask

    initial begin
        repeat (20000) @(posedge clk);
        $display("timeout of the whole run, simulation stopped");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int             e;
        id_ex_reg_t     r;
        funct3_branch_e conds [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        clk = 1'b0;
        rst_n = 1'b1;
        id_ex_in = '0;
        wb_write_data = '0;
        wb_rd_addr = '0;
        wb_reg_write = 1'b0;
        stall = 1'b0;
        flush = 1'b0;

        e = errors;
        #1;
        rst_n = 1'b0; // falling edge before the first clock
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        end_test("reset", e);

        e = errors;
        for (int k = 0; k < 11; k++) begin
            for (int s = 0; s < 2; s++) begin
                drive(make_rec(s ? OP_IMM : OP_REG, alu_op_e'(4'(k)), s[0], 3'd0,
                               rand_bits(5), rand_bits(5), rand_bits(5)),
                      1'b0, 1'b0, rand_bits(1), rand_bits(5));
            end
        end
        repeat (3) begin
            drive(make_rec(OP_LUI, PASS_B, 1'b1, 3'd0, 5'd0, 5'd0, rand_bits(5)), 0, 0, 0, 0);
            drive(make_rec(OP_AUIPC, ADD, 1'b1, 3'd0, 5'd0, 5'd0, rand_bits(5)), 0, 0, 0, 0);
            drive(make_rec(OP_LOAD, ADD, 1'b1, 3'd2, rand_bits(5), 5'd0, 5'd4), 0, 0, 0, 0);
            drive(make_rec(OP_STORE, ADD, 1'b1, 3'd2, rand_bits(5), rand_bits(5), 5'd0),
                  0, 0, 0, 0);
        end
        end_test("alu", e);

        e = errors;
        drive(make_rec(OP_REG, ADD, 1'b0, 3'd0, 5'd1, 5'd2, 5'd5), 0, 0, 0, 0);
        drive(make_rec(OP_REG, XOR, 1'b0, 3'd0, 5'd5, 5'd5, 5'd9), 0, 0, 1, 5'd5); // mem wins
        drive(make_rec(OP_STORE, ADD, 1'b1, 3'd2, 5'd7, 5'd7, 5'd0), 0, 0, 1, 5'd7); // wb
        drive(make_rec(OP_IMM, ADD, 1'b1, 3'd0, 5'd3, 5'd0, 5'd0), 0, 0, 0, 0);
        drive(make_rec(OP_REG, OR, 1'b0, 3'd0, 5'd0, 5'd0, 5'd3), 0, 0, 1, 5'd0); // x0
        repeat (40) begin
            drive(make_rec(OP_REG, alu_op_e'(4'(rand_bits(3))), 1'b0, 3'd0, rand_bits(2),
                           rand_bits(2), rand_bits(2)), 0, 0, rand_bits(1), rand_bits(2));
        end
        end_test("forwarding", e);

        e = errors;
        for (int c = 0; c < 6; c++) begin
            repeat (6) begin
                r = make_rec(OP_BRANCH, SUB, 1'b0, conds[c], rand_bits(5), rand_bits(5), 5'd0);
                if (rand_bits(1)) begin
                    r.rs2_addr = r.rs1_addr; // equal operands
                    r.rs2_data = r.rs1_data;
                end
                drive(r, 0, 0, rand_bits(1), rand_bits(5));
            end
        end
        repeat (4) begin
            drive(make_rec(OP_JAL, ADD, 1'b1, 3'd0, 5'd0, 5'd0, 5'd1), 0, 0, 0, 0);
            r = make_rec(OP_JALR, ADD, 1'b1, 3'd0, rand_bits(5), 5'd0, 5'd1);
            r.immediate[0] = 1'b1; // odd target
            drive(r, 0, 0, 0, 0);
        end
        end_test("branch", e);

        e = errors;
        drive('0, 0, 1, 0, 0);
        drive(make_rec(OP_IMM, ADD, 1'b1, 3'd0, 5'd8, 5'd0, 5'd6), 0, 0, 0, 0);
        wait_out_valid(10);
        repeat (3) begin
            drive(make_rec(OP_REG, SUB, 1'b0, 3'd0, rand_bits(5), rand_bits(5), 5'd7),
                  1, 0, 0, 0);
        end
        drive(make_rec(OP_STORE, ADD, 1'b1, 3'd2, 5'd1, 5'd2, 5'd0), 1, 1, 0, 0);
        r = make_rec(OP_BRANCH, SUB, 1'b0, BEQ, 5'd4, 5'd4, 5'd0);
        r.rs2_data    = r.rs1_data;
        r.valid_id_ex = 1'b0;
        drive(r, 0, 0, 0, 0);
        r = make_rec(OP_JAL, ADD, 1'b1, 3'd0, 5'd0, 5'd0, 5'd1);
        r.valid_id_ex = 1'b0;
        drive(r, 0, 1, 0, 0);
        drive('0, 0, 0, 0, 0);
        end_test("stall_flush", e);

        if (mem_hits == 0) begin
            errors++;
            $display("forwarding from the EX/MEM record was never exercised");
        end
        if (wb_hits == 0) begin
            errors++;
            $display("forwarding from write-back was never exercised");
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_top.sv
`default_nettype none

module ex_top
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  id_ex_reg_t  id_ex_in,
    input  word_t       wb_write_data,  // write-back forwarding
    input  reg_addr_t   wb_rd_addr,
    input  logic        wb_reg_write,
    input  logic        stall,
    input  logic        flush,
    output logic        branch_taken,   // same cycle
    output word_t       branch_target,
    output ex_mem_reg_t ex_mem_out      // one cycle later
);

    ex_mem_reg_t ex_mem_next;

    ex_stage u_ex_stage (
        .id_ex_in     (id_ex_in),
        .ex_mem_fwd   (ex_mem_out),     // mem forwarding loop
        .wb_write_data(wb_write_data),
        .wb_rd_addr   (wb_rd_addr),
        .wb_reg_write (wb_reg_write),
        .branch_taken (branch_taken),
        .branch_target(branch_target),
        .ex_mem_next  (ex_mem_next)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .stall(stall),
        .flush(flush),
        .d    (ex_mem_next),
        .q    (ex_mem_out)
    );

endmodule

`default_nettype wire

//--- ex_mem_reg.sv
`default_nettype none

module ex_mem_reg
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,  // hold current record
    input  logic        flush,  // insert bubble, beats stall
    input  ex_mem_reg_t d,
    output ex_mem_reg_t q
);

    // all-zero record is a bubble: invalid, no writes
    localparam ex_mem_reg_t BUBBLE = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= BUBBLE;
        end else if (flush) begin
            q <= BUBBLE;
        end else if (!stall) begin
            q <= d;
        end
        // stall: q keeps its value
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage
    import riscv_pkg::*;
(
    input  id_ex_reg_t  id_ex_in,
    input  ex_mem_reg_t ex_mem_fwd,    // registered ex/mem as mem source
    input  word_t       wb_write_data,
    input  reg_addr_t   wb_rd_addr,
    input  logic        wb_reg_write,
    output logic        branch_taken,
    output word_t       branch_target,
    output ex_mem_reg_t ex_mem_next
);

    forward_src_e   forward_a;
    forward_src_e   forward_b;
    word_t          rs1_fwd;
    word_t          rs2_fwd;
    word_t          alu_a;
    word_t          alu_b;
    word_t          alu_result;
    word_t          link_addr;
    funct3_branch_e funct3_branch;
    logic           jump;

    function automatic word_t fwd_value(input forward_src_e sel, input word_t reg_val,
                                        input word_t mem_val, input word_t wb_val);
        word_t val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    forwarding_unit u_fwd (
        .rs1_addr    (id_ex_in.rs1_addr),
        .rs2_addr    (id_ex_in.rs2_addr),
        .ex_mem_fwd  (ex_mem_fwd),
        .wb_rd_addr  (wb_rd_addr),
        .wb_reg_write(wb_reg_write),
        .forward_a   (forward_a),
        .forward_b   (forward_b)
    );

    assign rs1_fwd = fwd_value(forward_a, id_ex_in.rs1_data, ex_mem_fwd.alu_result,
                               wb_write_data);
    assign rs2_fwd = fwd_value(forward_b, id_ex_in.rs2_data, ex_mem_fwd.alu_result,
                               wb_write_data);

    // auipc adds the immediate to pc
    assign alu_a = (id_ex_in.ctrl.opcode == OP_AUIPC) ? id_ex_in.pc : rs1_fwd;
    assign alu_b = id_ex_in.ctrl.alu_src ? id_ex_in.immediate : rs2_fwd;

    alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (id_ex_in.ctrl.alu_op),
        .result(alu_result),
        .zero  ()            // branch unit does its own compare
    );

    assign funct3_branch = funct3_branch_e'(id_ex_in.funct3_for_branch);

    branch_unit u_branch (
        .rs1_data     (rs1_fwd),
        .rs2_data     (rs2_fwd),
        .pc           (id_ex_in.pc),
        .imm          (id_ex_in.immediate),
        .funct3       (funct3_branch),
        .opcode       (id_ex_in.ctrl.opcode),
        .valid        (id_ex_in.valid_id_ex),
        .branch_taken (branch_taken),
        .branch_target(branch_target),
        .link_addr    (link_addr)
    );

    assign jump = id_ex_in.ctrl.is_jump || id_ex_in.ctrl.is_jalr;

    // jumps write the return address to rd
    always_comb begin
        ex_mem_next.alu_result   = jump ? link_addr : alu_result;
        ex_mem_next.rs2_data_str = rs2_fwd; // store data after forwarding
        ex_mem_next.rd_addr      = id_ex_in.rd_addr;
        ex_mem_next.ctrl         = id_ex_in.ctrl;
        ex_mem_next.valid_ex_mem = id_ex_in.valid_id_ex;
    end

endmodule

`default_nettype wire

//--- branch_unit.sv
`default_nettype none

module branch_unit
    import riscv_pkg::*;
(
    input  word_t          rs1_data,  // forwarded
    input  word_t          rs2_data,  // forwarded
    input  word_t          pc,
    input  word_t          imm,
    input  funct3_branch_e funct3,
    input  opcode_e        opcode,
    input  logic           valid,
    output logic           branch_taken,
    output word_t          branch_target,
    output word_t          link_addr
);

    logic  cond;       // branch compare outcome
    word_t target_sum;

    always_comb begin
        case (funct3)
            BEQ:  cond = (rs1_data == rs2_data);
            BNE:  cond = (rs1_data != rs2_data);
            BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
            BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU: cond = (rs1_data < rs2_data);
            BGEU: cond = (rs1_data >= rs2_data);
            default: begin
                cond = 1'b0; // funct3 010/011 are not branches
            end
        endcase
    end

    always_comb begin
        branch_taken = 1'b0;
        if (valid) begin
            case (opcode)
                OP_BRANCH: branch_taken = cond;
                OP_JAL:    branch_taken = 1'b1;
                OP_JALR:   branch_taken = 1'b1;
                default:   branch_taken = 1'b0;
            endcase
        end
    end

    // jalr is register relative, everything else pc relative
    assign target_sum    = ((opcode == OP_JALR) ? rs1_data : pc) + imm;
    assign branch_target = (opcode == OP_JALR) ? {target_sum[XLEN-1:1], 1'b0}
                                               : target_sum;

    assign link_addr = pc + word_t'(4);

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu
    import riscv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result,
    output logic    zero
);

    logic [4:0] shamt; // rv32 shifts use 5 bits

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            SLL:  result = a << shamt;
            SLT: begin
                result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            end
            SLTU: begin
                result = (a < b) ? word_t'(1) : '0;
            end
            XOR:  result = a ^ b;
            SRL:  result = a >> shamt;
            SRA:  result = word_t'($signed(a) >>> shamt); // keeps sign
            OR:   result = a | b;
            AND:  result = a & b;
            PASS_B: begin
                result = b; // lui immediate straight through
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- forwarding_unit.sv
`default_nettype none

module forwarding_unit
    import riscv_pkg::*;
(
    input  reg_addr_t    rs1_addr,
    input  reg_addr_t    rs2_addr,
    input  ex_mem_reg_t  ex_mem_fwd,   // current ex/mem record
    input  reg_addr_t    wb_rd_addr,
    input  logic         wb_reg_write,
    output forward_src_e forward_a,
    output forward_src_e forward_b
);

    logic mem_writes; // ex/mem will write a real register
    logic wb_writes;

    assign mem_writes = ex_mem_fwd.valid_ex_mem && ex_mem_fwd.ctrl.reg_write
                        && (ex_mem_fwd.rd_addr != '0);
    assign wb_writes  = wb_reg_write && (wb_rd_addr != '0);

    // newest producer wins, so mem is checked before wb
    function automatic forward_src_e pick_src(input reg_addr_t src, input logic mem_ok,
                                              input reg_addr_t mem_rd, input logic wb_ok,
                                              input reg_addr_t wb_rd);
        forward_src_e sel;
        if (mem_ok && (mem_rd == src)) begin
            sel = FWD_MEM;
        end else if (wb_ok && (wb_rd == src)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    // x0 never matches since both writers need rd != 0
    assign forward_a = pick_src(rs1_addr, mem_writes, ex_mem_fwd.rd_addr,
                                wb_writes, wb_rd_addr);
    assign forward_b = pick_src(rs2_addr, mem_writes, ex_mem_fwd.rd_addr,
                                wb_writes, wb_rd_addr);

endmodule

`default_nettype wire

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int FUNCT3_WIDTH   = 3;

    typedef logic [XLEN-1:0]           word_t;     // data or address
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t; // x0..x31
    typedef logic [FUNCT3_WIDTH-1:0]   funct3_t;   // raw funct3 from decode

    // alu operation select, set by decode
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0, // value from id/ex
        FWD_MEM  = 2'd1, // ex/mem alu result
        FWD_WB   = 2'd2  // write-back data
    } forward_src_e;

    // major opcodes, rv32i encodings
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [FUNCT3_WIDTH-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } funct3_branch_e;

    typedef struct packed {
        opcode_e opcode;
        alu_op_e alu_op;
        logic    alu_src;   // b from immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    is_jump;   // jal or jalr
        logic    is_jalr;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     immediate;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        funct3_t   funct3_for_branch;
        ctrl_t     ctrl;
        logic      valid_id_ex;
    } id_ex_reg_t;

    typedef struct packed {
        word_t     alu_result;   // also load/store address
        word_t     rs2_data_str; // store data
        reg_addr_t rd_addr;
        ctrl_t     ctrl;
        logic      valid_ex_mem;
    } ex_mem_reg_t;

endpackage

`default_nettype wire
